/* design/wbc_bus_pkg.sv */
//--------------------------------------------------
// bus types and address map of the subsystem
// all addresses are byte addresses, data is 16-bit
// RAM below 040000, console at 177560, board regs at 177700
//--------------------------------------------------
package wbc_bus_pkg;

   typedef logic [15:0] bus_addr_t;       // byte address
   typedef logic [15:0] bus_data_t;       // data word
   typedef logic [1:0]  bus_sel_t;        // byte lanes, bit 0 is the low byte

   typedef enum logic [1:0]
   {
      RAM,                                // 8K words of RAM
      UART,                               // console transmitter
      SYSREG,                             // board registers
      NONE                                // unmapped, fabric answers
   } slave_id_t;

   localparam logic [1:0] RAM_TOP_BITS = 2'b00;          // adr[15:14] of the RAM window
   localparam bus_addr_t  UART_BASE    = 16'o177560;     // 8 bytes, 177560..177567
   localparam bus_addr_t  SYSREG_BASE  = 16'o177700;     // 16 bytes, 177700..177717

endpackage

/* design/wbc_dev_pkg.sv */
//--------------------------------------------------
// device register offsets, vectors and FSM states
// console offsets follow the DL11 transmit half
// vector indices must match the wiring of the VIC
//--------------------------------------------------
package wbc_dev_pkg;

   typedef enum logic [2:0]
   {
      XCSR = 3'o4,                        // transmit status
      XBUF = 3'o6                         // transmit buffer
   } uart_reg_t;

   typedef enum logic [3:0]
   {
      CTRL    = 4'h0,                     // led bits and tick enable
      BUTTON  = 4'h2,                     // button level
      SCRATCH = 4'h4                      // free word
   } sysreg_reg_t;

   typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_t;

   typedef logic [15:0] ivec_t;

   localparam ivec_t VEC_UART_TX = 16'o000064;
   localparam ivec_t VEC_TICK    = 16'o000100;

   localparam int XCSR_READY   = 7;       // transmitter can take a byte
   localparam int XCSR_IE      = 6;       // interrupt enable
   localparam int CTRL_TICK_EN = 0;
   localparam int CTRL_LED     = 1;       // lsb of the 2-bit led field

   localparam int IRQ_TX   = 0;           // highest priority
   localparam int IRQ_TICK = 1;

endpackage

/* design/wbc_slave_if.sv */
//--------------------------------------------------
// one decoded slave port of the Wishbone fabric
// stb already carries cyc and the address decode
// the master holds stb until ack is seen
//--------------------------------------------------
`timescale 1ns/1ps

interface wbc_slave_if import wbc_bus_pkg::*; ();

   bus_addr_t adr;                        // byte address
   bus_data_t dat_w;                      // write data
   bus_data_t dat_r;                      // read data, valid with ack
   logic      we;                         // 1 = write
   bus_sel_t  sel;                        // byte lanes
   logic      stb;                        // qualified strobe
   logic      ack;                        // slave acknowledge

   modport master
   (
      output adr, dat_w, we, sel, stb,
      input  dat_r, ack
   );

   modport slave
   (
      input  adr, dat_w, we, sel, stb,
      output dat_r, ack
   );

endinterface

/* design/wbc_bus_fabric.sv */
//--------------------------------------------------
// address decode, read mux and ack merge
// unmapped accesses get a one-cycle ack, reads return 0
// one master only, no arbitration
//--------------------------------------------------
`timescale 1ns/1ps

module wbc_bus_fabric import wbc_bus_pkg::*;
(
   input  logic        wb_clk,
   input  logic        reset_i,
   input  bus_addr_t   wb_adr_i,
   input  bus_data_t   wb_dat_i,
   input  logic        wb_we_i,
   input  bus_sel_t    wb_sel_i,
   input  logic        wb_cyc_i,
   input  logic        wb_stb_i,
   output bus_data_t   wb_dat_o,
   output logic        wb_ack_o,
   wbc_slave_if.master ram_m,
   wbc_slave_if.master uart_m,
   wbc_slave_if.master sys_m
);

   slave_id_t sid;                        // decoded target
   logic      req;                        // live bus request
   logic      none_ack;                   // ack for unmapped space

   assign req = wb_cyc_i & wb_stb_i;

   always_comb
   begin
      if (wb_adr_i[15:14] == RAM_TOP_BITS)
         sid = RAM;
      else if (wb_adr_i[15:3] == UART_BASE[15:3])
         sid = UART;
      else if (wb_adr_i[15:4] == SYSREG_BASE[15:4])
         sid = SYSREG;
      else
         sid = NONE;
   end

   assign ram_m.adr    = wb_adr_i;
   assign ram_m.dat_w  = wb_dat_i;
   assign ram_m.we     = wb_we_i;
   assign ram_m.sel    = wb_sel_i;
   assign ram_m.stb    = req & (sid == RAM);
   assign uart_m.adr   = wb_adr_i;
   assign uart_m.dat_w = wb_dat_i;
   assign uart_m.we    = wb_we_i;
   assign uart_m.sel   = wb_sel_i;
   assign uart_m.stb   = req & (sid == UART);
   assign sys_m.adr    = wb_adr_i;
   assign sys_m.dat_w  = wb_dat_i;
   assign sys_m.we     = wb_we_i;
   assign sys_m.sel    = wb_sel_i;
   assign sys_m.stb    = req & (sid == SYSREG);

   always_ff @(posedge wb_clk)
   begin
      if (reset_i)
         none_ack <= 1'b0;
      else
         none_ack <= req & (sid == NONE) & ~none_ack;   // one pulse per access
   end

   always_comb
   begin
      case (sid)
         RAM:     wb_dat_o = ram_m.dat_r;
         UART:    wb_dat_o = uart_m.dat_r;
         SYSREG:  wb_dat_o = sys_m.dat_r;
         default: wb_dat_o = '0;          // unmapped reads as zero
      endcase
   end

   assign wb_ack_o = ram_m.ack | uart_m.ack | sys_m.ack | none_ack;

endmodule

/* design/wbc_ram.sv */
//--------------------------------------------------
// 8K x 16 RAM, word index from adr[13:1]
// write ack is combinational, read ack two clocks later
// master must drop stb one clock between accesses
// contents are undefined after power-up
//--------------------------------------------------
`timescale 1ns/1ps

module wbc_ram import wbc_bus_pkg::*;
(
   input  logic       wb_clk,
   wbc_slave_if.slave s
);

   bus_data_t   mem [0:8191];             // inferred block RAM
   bus_data_t   rdata;                    // registered read port
   logic [12:0] widx;                     // word index
   logic [1:0]  ack;                      // read ack pipeline

   assign widx = s.adr[13:1];

   always_ff @(posedge wb_clk)
   begin
      if (s.stb & s.we)
      begin
         if (s.sel[0])
            mem[widx][7:0] <= s.dat_w[7:0];      // low lane
         if (s.sel[1])
            mem[widx][15:8] <= s.dat_w[15:8];    // high lane
      end
      rdata <= mem[widx];
   end

   always_ff @(posedge wb_clk)
   begin
      ack[0] <= s.stb;                    // data out of the array
      ack[1] <= s.stb & ack[0];           // data settled at the mux
   end

   assign s.ack   = s.stb & (ack[1] | s.we);
   assign s.dat_r = rdata;

endmodule

/* design/wbc_uart_tx.sv */
//--------------------------------------------------
// console transmitter, DL11 register layout, 8N1 only
// BAUD_DIV clocks per bit, at least 2
// XBUF write while not ready is lost, XBUF reads zero
// sel is ignored, all writes are word writes
//--------------------------------------------------
`timescale 1ns/1ps

module wbc_uart_tx import wbc_dev_pkg::*;
#(
   parameter int BAUD_DIV = 8
)
(
   input  logic       wb_clk,
   input  logic       reset_i,
   wbc_slave_if.slave s,
   output logic       tx_o,
   output logic       irq_o,
   input  logic       irq_ack_i
);

   localparam int BW = $clog2(BAUD_DIV);

   uart_reg_t     rsel;                   // register offset
   tx_state_t     state;
   logic [BW-1:0] baud_cnt;               // clocks within a bit
   logic [2:0]    bit_cnt;                // data bit number
   logic [7:0]    xbuf;                   // shifts out lsb first
   logic          ready, ie;              // XCSR bits
   logic          irq_cond_q;             // ready & ie, last clock
   logic          pend;
   logic          ack;
   logic          wr, load, bit_end;

   assign rsel    = uart_reg_t'(s.adr[2:0]);
   assign wr      = s.stb & s.we & ~ack;  // first clock of a write only
   assign load    = wr & (rsel == XBUF) & ready;
   assign bit_end = (baud_cnt == BW'(BAUD_DIV - 1));

   always_ff @(posedge wb_clk)
   begin
      if (reset_i)
      begin
         ack        <= 1'b0;
         ready      <= 1'b1;
         ie         <= 1'b0;
         state      <= IDLE;
         baud_cnt   <= '0;
         bit_cnt    <= '0;
         irq_cond_q <= 1'b0;
         pend       <= 1'b0;
      end
      else
      begin
         ack <= s.stb & ~ack;
         if (wr && rsel == XCSR)
            ie <= s.dat_w[XCSR_IE];
         if (load)
         begin
            ready    <= 1'b0;
            state    <= START;
            baud_cnt <= '0;
         end
         else if (state != IDLE)
         begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            if (bit_end)
            begin
               case (state)
                  START:
                  begin
                     state   <= DATA;
                     bit_cnt <= '0;
                  end
                  DATA:
                  begin
                     bit_cnt <= bit_cnt + 1'b1;
                     if (bit_cnt == 3'd7)
                        state <= STOP;
                  end
                  default:                // end of stop bit
                  begin
                     state <= IDLE;
                     ready <= 1'b1;
                  end
               endcase
            end
         end
         irq_cond_q <= ready & ie;
         if (ready & ie & ~irq_cond_q)    // ready rose or ie was set
            pend <= 1'b1;
         else if (irq_ack_i)
            pend <= 1'b0;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (load)
         xbuf <= s.dat_w[7:0];
      else if (state == DATA && bit_end)
         xbuf <= {1'b0, xbuf[7:1]};
   end

   always_comb
   begin
      s.dat_r = '0;
      if (rsel == XCSR)
      begin
         s.dat_r[XCSR_READY] = ready;
         s.dat_r[XCSR_IE]    = ie;
      end
   end

   assign s.ack = ack;
   assign tx_o  = (state == START) ? 1'b0 : (state == DATA) ? xbuf[0] : 1'b1;
   assign irq_o = pend;

endmodule

/* design/wbc_sysreg.sv */
//--------------------------------------------------
// control, button and scratch board registers
// button_i must already be synchronous and debounced
// sel is ignored, all writes are word writes
//--------------------------------------------------
`timescale 1ns/1ps

module wbc_sysreg import wbc_bus_pkg::*, wbc_dev_pkg::*;
#(
   parameter int TICK_DIV = 64
)
(
   input  logic       wb_clk,
   input  logic       reset_i,
   wbc_slave_if.slave s,
   input  logic       button_i,
   output logic [1:0] led_o,
   output logic       irq_o,
   input  logic       irq_ack_i
);

   localparam int TW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

   sysreg_reg_t   rsel;                   // register offset
   logic [2:0]    ctrl;                   // led field and tick enable
   bus_data_t     scratch;
   logic [TW-1:0] tick_cnt;
   logic          tick;                   // last clock of a tick period
   logic          pend, ack, wr;

   assign rsel = sysreg_reg_t'(s.adr[3:0]);
   assign wr   = s.stb & s.we & ~ack;
   assign tick = ctrl[CTRL_TICK_EN] & (tick_cnt == TW'(TICK_DIV - 1));

   always_ff @(posedge wb_clk)
   begin
      if (reset_i)
      begin
         ack      <= 1'b0;
         ctrl     <= '0;
         tick_cnt <= '0;
         pend     <= 1'b0;
      end
      else
      begin
         ack <= s.stb & ~ack;
         if (wr && rsel == CTRL)
            ctrl <= s.dat_w[2:0];
         if (!ctrl[CTRL_TICK_EN] || tick)
            tick_cnt <= '0;               // restart period
         else
            tick_cnt <= tick_cnt + 1'b1;
         if (tick)
            pend <= 1'b1;
         else if (irq_ack_i)
            pend <= 1'b0;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr && rsel == SCRATCH)
         scratch <= s.dat_w;
   end

   always_comb
   begin
      case (rsel)
         CTRL:    s.dat_r = {13'd0, ctrl};
         BUTTON:  s.dat_r = {15'd0, button_i};
         SCRATCH: s.dat_r = scratch;
         default: s.dat_r = '0;
      endcase
   end

   assign s.ack = ack;
   assign led_o = ctrl[CTRL_LED +: 2];
   assign irq_o = pend;

endmodule

/* design/wbc_vic.sv */
//--------------------------------------------------
// vectored interrupt controller, two sources
// fixed priority, transmitter above tick
// a vector cycle with nothing pending returns 0
//--------------------------------------------------
`timescale 1ns/1ps

module wbc_vic import wbc_dev_pkg::*;
(
   input  logic       wb_clk,
   input  logic       reset_i,
   input  logic [1:0] irq_i,
   output logic [1:0] irq_ack_o,
   input  logic       ivec_stb_i,
   output logic       ivec_ack_o,
   output ivec_t      ivec_dat_o
);

   ivec_t      vec;                       // vector of the winner
   logic [1:0] grant;                     // one-hot winner
   logic       take;                      // first clock of a vector cycle

   assign take = ivec_stb_i & ~ivec_ack_o;

   always_comb
   begin
      vec   = '0;
      grant = '0;
      if (irq_i[IRQ_TX])
      begin
         vec           = VEC_UART_TX;
         grant[IRQ_TX] = 1'b1;
      end
      else if (irq_i[IRQ_TICK])
      begin
         vec             = VEC_TICK;
         grant[IRQ_TICK] = 1'b1;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (reset_i)
      begin
         ivec_ack_o <= 1'b0;
         irq_ack_o  <= '0;
      end
      else
      begin
         ivec_ack_o <= take;
         irq_ack_o  <= take ? grant : 2'b00;   // pulse with the ack
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (take)
         ivec_dat_o <= vec;               // held through the ack clock
   end

endmodule

/* design/wbc_subsys.sv */
//--------------------------------------------------
// peripheral subsystem of the 16-bit Wishbone computer
// one external master, single clock domain
// no registers here, slave latencies pass straight out
// irq_o stays high while any source is pending
//--------------------------------------------------
`timescale 1ns/1ps

module wbc_subsys import wbc_bus_pkg::*, wbc_dev_pkg::*;
#(
   parameter int BAUD_DIV = 8,
   parameter int TICK_DIV = 64
)
(
   input  logic       wb_clk,
   input  logic       reset_i,
   input  bus_addr_t  wb_adr_i,
   input  bus_data_t  wb_dat_i,
   output bus_data_t  wb_dat_o,
   input  logic       wb_we_i,
   input  bus_sel_t   wb_sel_i,
   input  logic       wb_cyc_i,
   input  logic       wb_stb_i,
   output logic       wb_ack_o,
   input  logic       ivec_stb_i,
   output logic       ivec_ack_o,
   output ivec_t      ivec_dat_o,
   input  logic       button_i,
   output logic [1:0] led_o,
   output logic       uart_tx_o,
   output logic       irq_o
);

   logic [1:0] irq;                       // requests, by IRQ_ index
   logic [1:0] irq_ack;                   // served pulses
   logic       irq_tx, irq_tick;
   logic       irq_ack_tx, irq_ack_tick;

   wbc_slave_if ram_bus ();
   wbc_slave_if uart_bus ();
   wbc_slave_if sys_bus ();

   wbc_bus_fabric i_fabric
   (
      .wb_clk   (wb_clk),
      .reset_i  (reset_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_we_i  (wb_we_i),
      .wb_sel_i (wb_sel_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .ram_m    (ram_bus.master),
      .uart_m   (uart_bus.master),
      .sys_m    (sys_bus.master)
   );

   wbc_ram i_ram
   (
      .wb_clk (wb_clk),
      .s      (ram_bus.slave)
   );

   wbc_uart_tx #(.BAUD_DIV(BAUD_DIV)) i_uart
   (
      .wb_clk    (wb_clk),
      .reset_i   (reset_i),
      .s         (uart_bus.slave),
      .tx_o      (uart_tx_o),
      .irq_o     (irq_tx),
      .irq_ack_i (irq_ack_tx)
   );

   wbc_sysreg #(.TICK_DIV(TICK_DIV)) i_sysreg
   (
      .wb_clk    (wb_clk),
      .reset_i   (reset_i),
      .s         (sys_bus.slave),
      .button_i  (button_i),
      .led_o     (led_o),
      .irq_o     (irq_tick),
      .irq_ack_i (irq_ack_tick)
   );

   wbc_vic i_vic
   (
      .wb_clk     (wb_clk),
      .reset_i    (reset_i),
      .irq_i      (irq),
      .irq_ack_o  (irq_ack),
      .ivec_stb_i (ivec_stb_i),
      .ivec_ack_o (ivec_ack_o),
      .ivec_dat_o (ivec_dat_o)
   );

   assign irq[IRQ_TX]   = irq_tx;
   assign irq[IRQ_TICK] = irq_tick;
   assign irq_ack_tx    = irq_ack[IRQ_TX];
   assign irq_ack_tick  = irq_ack[IRQ_TICK];
   assign irq_o         = irq_tx | irq_tick;    // to the cpu virq input

endmodule

/* verification/wbc_subsys_tb.sv */
//--------------------------------------------------
// trace-driven testbench of the peripheral subsystem
// run from the project root, the trace path is relative
// BAUD_DIV and TICK_DIV here must match the trace timing
// first mismatch or timeout ends the run with $fatal
//--------------------------------------------------
`timescale 1ns/1ps

module wbc_subsys_tb import wbc_bus_pkg::*, wbc_dev_pkg::*;
();

   localparam int BAUD_DIV   = 8;
   localparam int TICK_DIV   = 64;
   localparam int HALF_BIT   = BAUD_DIV / 2;        // sample point within a bit
   localparam int BUS_LIMIT  = 16;                  // clocks to wait for an ack
   localparam int POLL_LIMIT = 200;                 // register reads per poll
   localparam int IRQ_LIMIT  = 4 * TICK_DIV;
   localparam int RX_LIMIT   = 20 * BAUD_DIV;

   logic       wb_clk, reset_i;
   bus_addr_t  wb_adr_i;
   bus_data_t  wb_dat_i, wb_dat_o;
   logic       wb_we_i, wb_cyc_i, wb_stb_i, wb_ack_o;
   bus_sel_t   wb_sel_i;
   logic       ivec_stb_i, ivec_ack_o;
   ivec_t      ivec_dat_o;
   logic       button_i, uart_tx_o, irq_o;
   logic [1:0] led_o;

   logic [7:0] rx_q [$];                            // bytes seen on the line
   logic [7:0] mon_shift;
   logic       mon_busy;
   int         mon_cnt, mon_bit;

   wbc_subsys #(.BAUD_DIV(BAUD_DIV), .TICK_DIV(TICK_DIV)) i_wbc_subsys
   (
      .wb_clk(wb_clk), .reset_i(reset_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o),
      .wb_we_i(wb_we_i), .wb_sel_i(wb_sel_i), .wb_cyc_i(wb_cyc_i),
      .wb_stb_i(wb_stb_i), .wb_ack_o(wb_ack_o),
      .ivec_stb_i(ivec_stb_i), .ivec_ack_o(ivec_ack_o), .ivec_dat_o(ivec_dat_o),
      .button_i(button_i), .led_o(led_o), .uart_tx_o(uart_tx_o), .irq_o(irq_o)
   );

   initial
   begin
      wb_clk = 1'b0;
      forever #20 wb_clk = ~wb_clk;                 // 40 ns period
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
      if (got !== exp)
         abort_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_vector(input ivec_t got, input ivec_t exp);
      if (got !== exp)
         abort_run($sformatf("[ERROR] ivec_dat_o got %h expected %h", got, exp));
   endtask

   task automatic check_serial(input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
         abort_run($sformatf("[ERROR] uart_tx_o byte got %h expected %h", got, exp));
   endtask

   task automatic check_led(input logic [1:0] got, input logic [1:0] exp);
      if (got !== exp)
         abort_run($sformatf("[ERROR] led_o got %h expected %h", got, exp));
   endtask

   // one Wishbone cycle with stb held until ack and dropped for a clock after it
   task automatic bus_access(input logic we, input bus_addr_t adr, input bus_data_t dat,
                             input bus_sel_t sel, output bus_data_t rdat);
      int n;
      n = 0;
      @(posedge wb_clk);
      #2;
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_sel_i = sel;
      wb_we_i  = we;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      @(negedge wb_clk);                            // ack and data settle mid-clock
      while (wb_ack_o !== 1'b1)
      begin
         n++;
         if (n > BUS_LIMIT)
            abort_run($sformatf("no bus acknowledge for address %h", adr));
         @(negedge wb_clk);
      end
      rdat = wb_dat_o;
      @(posedge wb_clk);
      #2;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic vector_cycle(output ivec_t vec);
      int n;
      n = 0;
      @(posedge wb_clk);
      #2;
      ivec_stb_i = 1'b1;
      @(negedge wb_clk);
      while (ivec_ack_o !== 1'b1)
      begin
         n++;
         if (n > BUS_LIMIT)
            abort_run("no acknowledge for the interrupt vector cycle");
         @(negedge wb_clk);
      end
      vec = ivec_dat_o;
      @(posedge wb_clk);
      #2;
      ivec_stb_i = 1'b0;
   endtask

   task automatic take_serial(output logic [7:0] b);
      int n;
      n = 0;
      @(negedge wb_clk);
      while (rx_q.size() == 0)
      begin
         n++;
         if (n > RX_LIMIT)
            abort_run("no serial frame seen on uart_tx_o");
         @(negedge wb_clk);
      end
      b = rx_q.pop_front();
   endtask

   task automatic poll_reg(input bus_addr_t adr, input bus_data_t exp);
      int        n;
      bus_data_t rd;
      n = 0;
      bus_access(1'b0, adr, '0, 2'b11, rd);
      while (rd !== exp)
      begin
         n++;
         if (n > POLL_LIMIT)
            abort_run($sformatf("register at %h never read back %h", adr, exp));
         bus_access(1'b0, adr, '0, 2'b11, rd);
      end
   endtask

   task automatic wait_irq(input logic lvl);
      int n;
      n = 0;
      @(negedge wb_clk);
      while (irq_o !== lvl)
      begin
         n++;
         if (n > IRQ_LIMIT)
            abort_run($sformatf("irq_o did not go to %0d in time", lvl));
         @(negedge wb_clk);
      end
   endtask

   // serial line monitor counting clocks from the first low sample of the start bit
   always @(negedge wb_clk)
   begin
      if (reset_i)
         mon_busy = 1'b0;
      else if (!mon_busy)
      begin
         if (uart_tx_o === 1'b0)                    // start bit found
         begin
            mon_busy = 1'b1;
            mon_cnt  = 0;
         end
      end
      else
      begin
         mon_cnt++;
         if (mon_cnt >= HALF_BIT && (mon_cnt - HALF_BIT) % BAUD_DIV == 0)
         begin
            mon_bit = (mon_cnt - HALF_BIT) / BAUD_DIV;   // 0 start, 1..8 data, 9 stop
            if (mon_bit == 0 && uart_tx_o !== 1'b0)
               abort_run("start bit on uart_tx_o shorter than half a bit");
            else if (mon_bit >= 1 && mon_bit <= 8)
               mon_shift[mon_bit-1] = uart_tx_o;   // lsb first
            else if (mon_bit == 9)
            begin
               if (uart_tx_o !== 1'b1)
                  abort_run("stop bit on uart_tx_o is not high");
               rx_q.push_back(mon_shift);
               mon_busy = 1'b0;
            end
         end
      end
   end

   task automatic run_op(input logic [15:0] op, input bus_addr_t adr, input bus_data_t dat,
                         input bus_sel_t sel, input logic [15:0] exp);
      bus_data_t  rd;
      ivec_t      vec;
      logic [7:0] b;
      case (op)
         16'h0: bus_access(1'b1, adr, dat, sel, rd);
         16'h1:
         begin
            bus_access(1'b0, adr, '0, sel, rd);
            check_data($sformatf("wb_dat_o at %h", adr), rd, exp);
         end
         16'h2:
         begin
            vector_cycle(vec);
            check_vector(vec, exp);
         end
         16'h3:
         begin
            take_serial(b);
            check_serial(b, exp[7:0]);
         end
         16'h4:
         begin
            @(posedge wb_clk);
            #2;
            button_i = dat[0];
         end
         16'h5:
         begin
            @(negedge wb_clk);
            check_led(led_o, exp[1:0]);
         end
         16'h6: poll_reg(adr, exp);
         16'h7: wait_irq(exp[0]);
         default: abort_run($sformatf("unknown operation code %h in the trace", op));
      endcase
   endtask

   initial
   begin
      int          fd, cnt, ops;
      string       line;
      logic [15:0] f_op, f_adr, f_dat, f_sel, f_exp;
      reset_i    = 1'b1;
      wb_adr_i   = '0;
      wb_dat_i   = '0;
      wb_we_i    = 1'b0;
      wb_sel_i   = '0;
      wb_cyc_i   = 1'b0;
      wb_stb_i   = 1'b0;
      ivec_stb_i = 1'b0;
      button_i   = 1'b0;
      ops        = 0;
      repeat (10) @(posedge wb_clk);
      #2;
      reset_i = 1'b0;
      fd = $fopen("verification/wbc_subsys_trace.txt", "r");
      if (fd == 0)
         abort_run("cannot open verification/wbc_subsys_trace.txt");
      while (!$feof(fd))
      begin
         line = "";
         cnt  = $fgets(line, fd);
         if (cnt == 0 || line.getc(0) == "#" || line.getc(0) == "\n")
            continue;                               // comment or blank line
         cnt = $sscanf(line, "%h %h %h %h %h", f_op, f_adr, f_dat, f_sel, f_exp);
         if (cnt != 5)
            abort_run($sformatf("trace line without five fields: %s", line));
         run_op(f_op, f_adr, f_dat, f_sel[1:0], f_exp);
         ops++;
      end
      $fclose(fd);
      if (ops == 0)
         abort_run("trace file holds no operations");
      else
      begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

/* verification/wbc_subsys_trace.txt */
# op adr data sel expect, all hex; op 0 write 1 read 2 vector 3 serial
# 4 button 5 led 6 poll until expect 7 wait irq_o level
0 0100 1234 3 0000
1 0100 0000 3 1234
0 0100 abcd 2 0000
1 0100 0000 3 ab34
0 0100 5566 1 0000
1 0100 0000 3 ab66
0 0000 c001 3 0000
0 3ffe beef 3 0000
1 3ffe 0000 3 beef
1 0000 0000 3 c001
0 8000 dead 3 0000
1 8000 0000 3 0000
1 0000 0000 3 c001
1 0100 0000 3 ab66
0 ff76 00a5 3 0000
1 ff74 0000 3 0000
3 0000 0000 0 00a5
6 ff74 0000 3 0080
0 ffc0 0006 3 0000
5 0000 0000 0 0003
0 ffc4 5a3c 3 0000
1 ffc4 0000 3 5a3c
4 0000 0001 0 0000
1 ffc2 0000 3 0001
4 0000 0000 0 0000
1 ffc2 0000 3 0000
0 ff74 0040 3 0000
0 ffc0 0001 3 0000
2 0000 0000 0 0034
7 0000 0000 0 0001
2 0000 0000 0 0040
0 ffc0 0000 3 0000
2 0000 0000 0 0000
7 0000 0000 0 0000
5 0000 0000 0 0000

/* wbc_subsys.f */
design/wbc_bus_pkg.sv
design/wbc_dev_pkg.sv
design/wbc_slave_if.sv
design/wbc_bus_fabric.sv
design/wbc_ram.sv
design/wbc_uart_tx.sv
design/wbc_sysreg.sv
design/wbc_vic.sv
design/wbc_subsys.sv
verification/wbc_subsys_tb.sv

/* Makefile */
SIM        := verilator
TOP        := wbc_subsys_tb
RTL_TOP    := wbc_subsys
FLIST      := wbc_subsys.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FLIST) --top-module $(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
